/* files.f */
rv32i_types.sv
iq_if.sv
fetcher.sv
circular_q.sv
decoder.sv
cpu.sv
tb_imem.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module cpu_tb \
	-f files.f -o cpu_tb_sim || { echo "build failed"; exit 1; }
./obj_dir/cpu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
[ "$status" -eq 0 ] && grep -q "TEST PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

/* cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	import rv32i_types::*;

	localparam logic [31:0] seed_value  = 32'h5a54_d330;
	localparam int unsigned first_takes = 40;
	localparam int unsigned total_takes = 100;

	logic        clk;
	logic        rst_n;
	logic        rst_q;
	logic        mem_resp;
	logic [31:0] mem_rdata;
	logic        mem_read;
	logic [31:0] mem_address;
	logic        dec_take;
	logic        dec_valid;
	rv32i_opcode dec_opcode;
	logic [4:0]  dec_rd;
	logic [4:0]  dec_rs1;
	logic [4:0]  dec_rs2;
	logic [2:0]  dec_funct3;
	logic [6:0]  dec_funct7;
	logic [31:0] dec_imm;
	logic [31:0] dec_pc;
	logic        dec_illegal;
	logic [31:0] exp_word;   // image word at the head's pc.
	int unsigned fetched;    // responses accepted by the fetcher.
	int unsigned taken;
	integer      take_seed = seed_value;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	cpu u_cpu (
		.clk(clk), .rst_n(rst_n), .mem_resp(mem_resp), .mem_rdata(mem_rdata),
		.mem_read(mem_read), .mem_address(mem_address), .dec_take(dec_take),
		.dec_valid(dec_valid), .dec_opcode(dec_opcode), .dec_rd(dec_rd), .dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2), .dec_funct3(dec_funct3), .dec_funct7(dec_funct7),
		.dec_imm(dec_imm), .dec_pc(dec_pc), .dec_illegal(dec_illegal)
	);

	tb_imem #(.seed_init(seed_value)) u_imem (
		.clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_address(mem_address),
		.mem_resp(mem_resp), .mem_rdata(mem_rdata)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_q   <= 1'b0;
			fetched <= 0;
			taken   <= 0;
		end else begin
			rst_q <= 1'b1; // low through reset and the first cycle after it.
			if (mem_read && mem_resp) begin
				fetched <= fetched + 1;
			end
			if (dec_take) begin
				taken <= taken + 1;
			end
		end
	end

	assign exp_word = u_imem.image[dec_pc[7:2]];

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		stop_with_error($sformatf("mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
			$time, name, expected, actual));
	endtask

	function automatic logic is_base_opcode(input logic [6:0] op);
		case (op)
			op_lui, op_auipc, op_jal, op_jalr, op_br, op_load, op_store, op_imm, op_reg, op_csr:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] expected_imm(input logic [31:0] w);
		logic signed [31:0] s;
		logic signed [31:0] hi;
		logic signed [12:0] b;
		logic signed [20:0] j;
		s  = w;
		hi = s >>> 25;
		b  = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		j  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		case (w[6:0])
			op_lui, op_auipc:                 return {w[31:12], 12'h000};
			op_jalr, op_load, op_imm, op_csr: return s >>> 20;
			op_store:                         return {hi[26:0], w[11:7]};
			op_br:                            return 32'(b);
			op_jal:                           return 32'(j);
			default:                          return 32'h0; // r-type and unknown opcodes.
		endcase
	endfunction

	a_reset_quiet: assert property (@(posedge clk) !rst_q |-> !mem_read && !dec_valid)
		else stop_with_error("mem_read or dec_valid high in reset or the cycle after it");
	a_first_read: assert property (@(posedge clk) rst_n && !rst_q |=> mem_read)
		else stop_with_error("no read request on the first edge after reset");
	a_address: assert property (@(posedge clk) mem_read |-> mem_address == fetched * 4)
		else report_mismatch("mem_address", $sampled(fetched * 4), $sampled(mem_address));
	a_take_valid: assert property (@(posedge clk) dec_take |-> dec_valid)
		else stop_with_error("dec_take pulsed while the queue head was not valid");
	a_head_pc: assert property (@(posedge clk) dec_valid |-> dec_pc == taken * 4)
		else report_mismatch("dec_pc", $sampled(taken * 4), $sampled(dec_pc));
	a_fill: assert property (@(posedge clk) dec_valid == (fetched != taken))
		else stop_with_error("dec_valid disagrees with the fetched and taken counts");
	a_bound: assert property (@(posedge clk) fetched - taken <= iq_depth)
		else stop_with_error("more entries outstanding than the queue can hold");
	a_stall: assert property (@(posedge clk) fetched - taken == iq_depth |-> !mem_read)
		else stop_with_error("read request while the instruction queue is full");

	a_opcode: assert property (@(posedge clk) dec_valid |-> dec_opcode == exp_word[6:0])
		else report_mismatch("dec_opcode", 32'($sampled(exp_word[6:0])),
			32'($sampled(dec_opcode)));
	a_rd: assert property (@(posedge clk) dec_valid |-> dec_rd == exp_word[11:7])
		else report_mismatch("dec_rd", 32'($sampled(exp_word[11:7])), 32'($sampled(dec_rd)));
	a_rs1: assert property (@(posedge clk) dec_valid |-> dec_rs1 == exp_word[19:15])
		else report_mismatch("dec_rs1", 32'($sampled(exp_word[19:15])), 32'($sampled(dec_rs1)));
	a_rs2: assert property (@(posedge clk) dec_valid |-> dec_rs2 == exp_word[24:20])
		else report_mismatch("dec_rs2", 32'($sampled(exp_word[24:20])), 32'($sampled(dec_rs2)));
	a_funct3: assert property (@(posedge clk) dec_valid |-> dec_funct3 == exp_word[14:12])
		else report_mismatch("dec_funct3", 32'($sampled(exp_word[14:12])),
			32'($sampled(dec_funct3)));
	a_funct7: assert property (@(posedge clk) dec_valid |-> dec_funct7 == exp_word[31:25])
		else report_mismatch("dec_funct7", 32'($sampled(exp_word[31:25])),
			32'($sampled(dec_funct7)));
	a_imm: assert property (@(posedge clk) dec_valid |-> dec_imm == expected_imm(exp_word))
		else report_mismatch("dec_imm", expected_imm($sampled(exp_word)), $sampled(dec_imm));
	a_illegal: assert property (@(posedge clk)
		dec_valid |-> dec_illegal == !is_base_opcode(exp_word[6:0]))
		else report_mismatch("dec_illegal", 32'(!is_base_opcode($sampled(exp_word[6:0]))),
			32'($sampled(dec_illegal)));

	// takes are spaced at least two cycles apart so dec_valid read at the edge still holds.
	task automatic take_randomly(input int unsigned target, input int limit);
		int cycles;
		cycles = 0;
		while (taken < target) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				stop_with_error($sformatf("timeout waiting for %0d takes", target));
			end
			if (dec_take) begin
				dec_take <= 1'b0;
			end else begin
				dec_take <= dec_valid && (($random(take_seed) & 1) == 1);
			end
		end
	endtask

	task automatic wait_queue_full(input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				stop_with_error("timeout waiting for the instruction queue to fill");
			end
		end while (fetched - taken != iq_depth);
	endtask

	initial begin
		rst_n    = 1'b0;
		dec_take = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		take_randomly(first_takes, 2000);
		@(posedge clk);
		dec_take <= 1'b0;

		// without takes the fetcher must stall once the queue is full.
		wait_queue_full(200);
		repeat (20) @(posedge clk);
		dec_take <= 1'b1;
		@(posedge clk);
		dec_take <= 1'b0;
		wait_queue_full(100);
		repeat (20) @(posedge clk);

		take_randomly(total_takes, 3000);
		@(posedge clk);
		dec_take <= 1'b0;
		$display("TEST PASS");
		$finish;
	end

endmodule : cpu_tb

`default_nettype wire

/* tb_imem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_imem #(
	parameter logic [31:0] seed_init = 32'h5a54_d330
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        mem_read,
	input  wire logic [31:0] mem_address,
	output logic             mem_resp,
	output logic [31:0]      mem_rdata
);

	import rv32i_types::*;

	logic [31:0] image [64]; // program image, word addressed.
	logic [31:0] fill;
	logic        busy;
	logic [2:0]  cnt;        // cycles left until the response.
	integer      seed = seed_init;

	// mostly base opcodes, with a couple of encodings the decoder must flag.
	function automatic logic [6:0] pick_opcode(input logic [3:0] k);
		case (k)
			4'd0:    return op_lui;
			4'd1:    return op_auipc;
			4'd2:    return op_jal;
			4'd3:    return op_jalr;
			4'd4:    return op_br;
			4'd5:    return op_load;
			4'd6:    return op_store;
			4'd7:    return op_reg;
			4'd8:    return op_csr;
			4'd9:    return 7'b0001111; // misc-mem is not in the decoded set.
			4'd10:   return 7'b1111111;
			default: return op_imm;
		endcase
	endfunction

	initial begin
		for (int i = 0; i < 64; i++) begin
			fill = $random(seed);
			image[i] = {fill[31:7], pick_opcode(fill[3:0])};
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_resp  <= 1'b0;
			mem_rdata <= '0;
			busy      <= 1'b0;
			cnt       <= '0;
		end else begin
			mem_resp <= 1'b0; // a response lasts one cycle.
			if (busy) begin
				if (cnt == 3'd1) begin
					mem_resp  <= 1'b1;
					mem_rdata <= image[mem_address[7:2]];
					busy      <= 1'b0;
				end else begin
					cnt <= cnt - 3'd1;
				end
			end else if (mem_read && !mem_resp) begin
				busy <= 1'b1;
				cnt  <= 3'(($random(seed) & 3) + 1); // latency of 1 to 4 cycles.
			end
		end
	end

endmodule : tb_imem

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu (
	input  wire logic                    clk,
	input  wire logic                    rst_n,

	input  wire logic                    mem_resp,
	input  wire rv32i_types::rv32i_word  mem_rdata,
	output logic                         mem_read,
	output rv32i_types::rv32i_word       mem_address,

	input  wire logic                    dec_take,
	output logic                         dec_valid,
	output rv32i_types::rv32i_opcode     dec_opcode,
	output logic [4:0]                   dec_rd,
	output logic [4:0]                   dec_rs1,
	output logic [4:0]                   dec_rs2,
	output logic [2:0]                   dec_funct3,
	output logic [6:0]                   dec_funct7,
	output rv32i_types::rv32i_word       dec_imm,
	output rv32i_types::rv32i_word       dec_pc,
	output logic                         dec_illegal
);

	import rv32i_types::*;

	decoded_t dec;

	iq_if #(.T(iq_entry_t)) iq ();

	fetcher u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_resp    (mem_resp),
		.mem_rdata   (mem_rdata),
		.mem_read    (mem_read),
		.mem_address (mem_address),
		.iq          (iq.producer)
	);

	circular_q #(.T(iq_entry_t)) u_iq (
		.clk   (clk),
		.rst_n (rst_n),
		.q     (iq.queue)
	);

	decoder u_dec (
		.entry (iq.out),
		.dec   (dec)
	);

	assign iq.deq    = dec_take; // the consumer pops the head it has just seen.
	assign dec_valid = ~iq.empty;

	assign dec_opcode  = dec.opcode;
	assign dec_rd      = dec.rd;
	assign dec_rs1     = dec.rs1;
	assign dec_rs2     = dec.rs2;
	assign dec_funct3  = dec.funct3;
	assign dec_funct7  = dec.funct7;
	assign dec_imm     = dec.imm;
	assign dec_pc      = dec.pc;
	assign dec_illegal = dec.illegal;

endmodule : cpu

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder (
	input  wire rv32i_types::iq_entry_t entry,
	output rv32i_types::decoded_t       dec
);

	import rv32i_types::*;

	rv32i_word  instr;
	instr_fmt_t fmt;
	logic       illegal;
	rv32i_imm   imm;

	assign instr = entry.instr;

	// the opcode picks the immediate layout.
	always_comb begin
		illegal = 1'b0;
		case (instr[6:0])
			op_lui,
			op_auipc: fmt = fmt_u;
			op_jal:   fmt = fmt_j;
			op_jalr,
			op_load,
			op_imm,
			op_csr:   fmt = fmt_i; // csr keeps its address in the i-type field.
			op_br:    fmt = fmt_b;
			op_store: fmt = fmt_s;
			op_reg:   fmt = fmt_r;
			default: begin
				fmt     = fmt_r;
				illegal = 1'b1; // anything else falls back to an r-type with no immediate.
			end
		endcase
	end

	// immediates are rebuilt from their scattered bit fields.
	always_comb begin
		case (fmt)
			fmt_i: begin
				imm = {{21{instr[31]}}, instr[30:20]};
			end
			fmt_s: begin
				imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			end
			fmt_b: begin
				imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			fmt_u: begin
				imm = {instr[31:12], 12'h000};
			end
			fmt_j: begin
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

	always_comb begin
		dec.opcode  = rv32i_opcode'(instr[6:0]);
		dec.rd      = instr[11:7];
		dec.rs1     = instr[19:15];
		dec.rs2     = instr[24:20];
		dec.funct3  = instr[14:12];
		dec.funct7  = instr[31:25];
		dec.imm     = imm;
		dec.pc      = entry.pc;
		dec.fmt     = fmt;
		dec.illegal = illegal;
	end

endmodule : decoder

`default_nettype wire

/* circular_q.sv */
`timescale 1ns/1ns
`default_nettype none

module circular_q #(
	parameter type T = rv32i_types::iq_entry_t
) (
	input wire logic clk,
	input wire logic rst_n,
	iq_if.queue      q
);

	import rv32i_types::*;

	T                    mem [iq_depth];
	T                    head;
	logic [iq_ptr_w-1:0] wr_ptr;
	logic [iq_ptr_w-1:0] rd_ptr;
	logic [iq_ptr_w-1:0] rd_ptr_nxt;
	logic [iq_cnt_w-1:0] count;

	// wraps explicitly so the depth need not be a power of two.
	function automatic logic [iq_ptr_w-1:0] ptr_inc(input logic [iq_ptr_w-1:0] ptr);
		logic [iq_ptr_w-1:0] res;
		if (ptr == iq_ptr_w'(iq_depth - 1)) begin
			res = '0;
		end else begin
			res = ptr + 1'b1;
		end
		return res;
	endfunction

	assign rd_ptr_nxt = q.deq ? ptr_inc(rd_ptr) : rd_ptr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.enq) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			rd_ptr <= rd_ptr_nxt;
			case ({q.enq, q.deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither leave the fill level alone.
			endcase
		end
	end

	// storage and the registered head copy.
	always_ff @(posedge clk) begin
		if (q.enq) begin
			mem[wr_ptr] <= q.in;
		end
		if (q.enq && (wr_ptr == rd_ptr_nxt)) begin
			head <= q.in; // the new word lands right at the next head, so bypass the array.
		end else begin
			head <= mem[rd_ptr_nxt];
		end
	end

	assign q.out   = head;
	assign q.empty = (count == '0);
	assign q.full  = (count == iq_cnt_w'(iq_depth));

	a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n) q.deq |-> !q.empty)
		else $error("circular_q: dequeue from an empty queue");

	a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n) q.enq |-> !q.full)
		else $error("circular_q: enqueue into a full queue");

endmodule : circular_q

`default_nettype wire

/* fetcher.sv */
`timescale 1ns/1ns
`default_nettype none

module fetcher (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   mem_resp,
	input  wire rv32i_types::rv32i_word mem_rdata,
	output logic                        mem_read,
	output rv32i_types::rv32i_word      mem_address,
	iq_if.producer                      iq
);

	import rv32i_types::*;

	typedef enum logic {
		st_idle,
		st_wait
	} state_t;

	state_t    state;
	rv32i_word pc; // address of the next word to fetch.

	// one read is in flight at a time.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pc    <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (!iq.full) begin
						state <= st_wait; // only start a read that has a free slot.
					end
				end
				st_wait: begin
					if (mem_resp) begin
						state <= st_idle;
						pc    <= pc + 32'd4;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign mem_read    = (state == st_wait);
	assign mem_address = pc; // pc only moves on a response, so the address holds.

	// the response cycle writes straight into the queue.
	assign iq.enq = mem_read && mem_resp;
	assign iq.in  = iq_entry_t'{instr: mem_rdata, pc: pc};

	// the request must stay up on the same address until memory answers.
	property p_read_held;
		@(posedge clk) disable iff (!rst_n)
			mem_read && !mem_resp |=> mem_read && $stable(mem_address);
	endproperty

	a_read_held: assert property (p_read_held)
		else $error("fetcher: read dropped or address changed before mem_resp");

	// a read only starts with room in the queue, so the write never meets a full queue.
	property p_no_enq_full;
		@(posedge clk) disable iff (!rst_n)
			iq.enq |-> !iq.full;
	endproperty

	a_no_enq_full: assert property (p_no_enq_full)
		else $error("fetcher: enqueue while the instruction queue is full");

endmodule : fetcher

`default_nettype wire

/* iq_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface iq_if #(
	parameter type T = rv32i_types::iq_entry_t
);

	logic enq;   // one-cycle write strobe.
	T     in;    // entry written on enq.
	logic full;
	logic deq;   // one-cycle pop strobe.
	T     out;   // current head of the queue.
	logic empty;

	modport producer (
		output enq,
		output in,
		input  full
	);

	modport queue (
		input  enq,
		input  in,
		output full,
		input  deq,
		output out,
		output empty
	);

	modport consumer (
		output deq,
		input  out,
		input  empty
	);

endinterface : iq_if

`default_nettype wire

/* rv32i_types.sv */
`default_nettype none

package rv32i_types;

	localparam int iq_depth = 8; // instruction queue entries.
	localparam int iq_ptr_w = $clog2(iq_depth); // width of the read and write pointers.
	localparam int iq_cnt_w = $clog2(iq_depth + 1); // occupancy counts 0 up to iq_depth.

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [31:0] rv32i_imm; // immediate after sign extension and shift.

	// major opcodes of the base integer set.
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} instr_fmt_t;

	typedef struct packed {
		rv32i_word instr; // raw instruction word from memory.
		rv32i_word pc;    // address the word was fetched from.
	} iq_entry_t;

	typedef struct packed {
		rv32i_opcode opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		funct3_t     funct3;
		funct7_t     funct7;
		rv32i_imm    imm;
		rv32i_word   pc;
		instr_fmt_t  fmt;
		logic        illegal; // opcode is not one of the base set.
	} decoded_t;

endpackage : rv32i_types

`default_nettype wire
